//--- src/kl10_pkg.sv
package kl10_pkg;

  // KL10 words are numbered from the left, so bit 0 is the most significant
  typedef logic [0:35] word_t;
  typedef logic [0:5]  slice_t;

  // The EDP data path is spread over six boards of six bits each
  localparam int SLICE_W    = 6;
  localparam int EDP_SLICES = 6;

  typedef struct packed {
    logic  driving;
    word_t data;
  } ebus_driver_t;

  // Diagnostic function code with the board select in the upper four bits
  typedef logic [0:3] ds_brd_t;
  typedef logic [0:2] ds_fn_t;

  typedef struct packed {
    ds_brd_t brd;
    ds_fn_t  fn;
  } ds_t;

  localparam ds_fn_t DS_FN_READ  = 3'o0;
  localparam ds_fn_t DS_FN_WRITE = 3'o1;

  // Board code zero is left unassigned so an idle ds selects nothing
  localparam ds_brd_t DS_BRD_APR = 4'h1;
  localparam ds_brd_t DS_BRD_CTL = 4'h2;
  localparam ds_brd_t DS_BRD_EDP = 4'h3;

  typedef enum logic [1:0] {
    OP_EBUS_RD,
    OP_EBUS_WR,
    OP_MEM_RD,
    OP_MEM_WR
  } fe_op_t;

  // Physical memory address made of PMA bits 14 through 35
  typedef logic [14:35] mem_adr_t;

  localparam int MEM_WORDS      = 1024;
  localparam int MEM_ACK_DELAY  = 2;
  localparam int MEM_READ_DELAY = 3;

endpackage

//--- src/mbus_if.sv
`timescale 1ns/1ps

// Memory bus between the MBOX and one memory controller
interface mbus_if;

  // The MBOX holds start until the controller acknowledges
  logic                 start;
  logic                 rd_rq;
  logic                 wr_rq;
  kl10_pkg::mem_adr_t   adr;
  kl10_pkg::word_t      d_out;

  // The controller answers with single cycle ackn and in_valid pulses
  logic                 ackn;
  kl10_pkg::word_t      d_in;
  logic                 in_valid;

  modport mbox (
    output start, rd_rq, wr_rq, adr, d_out,
    input  ackn, d_in, in_valid
  );

  modport memory (
    input  start, rd_rq, wr_rq, adr, d_out,
    output ackn, d_in, in_valid
  );

endinterface

//--- src/ebus_slot.sv
`timescale 1ns/1ps

// One diagnostic register on the EBUS. A full word board uses word_t,
// an EDP slice uses slice_t and owns only its six bits of the word
module ebus_slot #(
  parameter type                payload_t = kl10_pkg::word_t,
  parameter kl10_pkg::ds_brd_t  BOARD     = kl10_pkg::DS_BRD_APR,
  parameter int                 LSB       = 35
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  kl10_pkg::ds_t          ebus_ds,
  input  logic                   ebus_diag_strobe,
  input  kl10_pkg::word_t        ebus_data,
  output kl10_pkg::ebus_driver_t drv
);

  localparam int W   = $bits(payload_t);
  // Leftmost bit of the field, since bit 0 is the most significant
  localparam int MSB = LSB - W + 1;

  payload_t value;
  logic     sel;
  logic     rd;
  logic     wr;

  assign sel = (ebus_ds.brd == BOARD);
  assign rd  = sel && (ebus_ds.fn == kl10_pkg::DS_FN_READ);
  assign wr  = sel && (ebus_ds.fn == kl10_pkg::DS_FN_WRITE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (wr && ebus_diag_strobe) begin
      value <= ebus_data[MSB +: W];
    end
  end

  // The slot drives back as soon as ds selects it for a read
  always_comb begin
    drv.driving = rd;
    drv.data    = '0;
    if (rd) begin
      drv.data[MSB +: W] = value;
    end
  end

endmodule

//--- src/ebus_mux.sv
`timescale 1ns/1ps

module ebus_mux (
  input  kl10_pkg::ebus_driver_t fe_drv,
  input  kl10_pkg::ebus_driver_t apr_drv,
  input  kl10_pkg::ebus_driver_t ctl_drv,
  input  kl10_pkg::ebus_driver_t edp_drv [kl10_pkg::EDP_SLICES],
  output kl10_pkg::word_t        ebus_data
);

  logic            edp_any;
  kl10_pkg::word_t edp_word;

  // Each EDP slice contributes only its own six bits.
  // Slice 0 sits at bits 30..35 and slice 5 at bits 0..5
  always_comb begin
    edp_any  = 1'b0;
    edp_word = '0;
    for (int i = 0; i < kl10_pkg::EDP_SLICES; i++) begin
      edp_any = edp_any | edp_drv[i].driving;
      edp_word[30 - kl10_pkg::SLICE_W * i +: kl10_pkg::SLICE_W] =
        edp_drv[i].data[30 - kl10_pkg::SLICE_W * i +: kl10_pkg::SLICE_W];
    end
  end

  // The front end wins over any board, an idle bus reads as zero
  always_comb begin
    if (fe_drv.driving) begin
      ebus_data = fe_drv.data;
    end else if (apr_drv.driving) begin
      ebus_data = apr_drv.data;
    end else if (ctl_drv.driving) begin
      ebus_data = ctl_drv.data;
    end else if (edp_any) begin
      ebus_data = edp_word;
    end else begin
      ebus_data = '0;
    end
  end

endmodule

//--- src/fe_diag_port.sv
`timescale 1ns/1ps

module fe_diag_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fe_req,
  input  kl10_pkg::fe_op_t       fe_op,
  input  kl10_pkg::ds_t          fe_ds,
  input  kl10_pkg::mem_adr_t     fe_adr,
  input  kl10_pkg::word_t        fe_wdata,
  input  kl10_pkg::word_t        ebus_data,
  input  logic                   mem_done,
  input  kl10_pkg::word_t        mem_rdata,
  output logic                   fe_ack,
  output kl10_pkg::word_t        fe_rdata,
  output kl10_pkg::ds_t          ebus_ds,
  output logic                   ebus_diag_strobe,
  output kl10_pkg::ebus_driver_t fe_drv,
  output logic                   mem_req,
  output logic                   mem_wr,
  output kl10_pkg::mem_adr_t     mem_adr,
  output kl10_pkg::word_t        mem_wdata
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SETUP,
    S_STROBE,
    S_MEM,
    S_ACK
  } state_t;

  state_t           state;
  kl10_pkg::fe_op_t cmd_op;
  logic             drv_on;
  kl10_pkg::word_t  drv_data;
  logic             accept;
  logic             is_ebus;

  // fe_ack is always low in idle, so idle with a request is a new command
  assign accept  = (state == S_IDLE) && fe_req;
  assign is_ebus = (fe_op == kl10_pkg::OP_EBUS_RD) || (fe_op == kl10_pkg::OP_EBUS_WR);
  assign fe_drv  = '{driving: drv_on, data: drv_data};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state            <= S_IDLE;
      cmd_op           <= kl10_pkg::OP_EBUS_RD;
      fe_ack           <= 1'b0;
      ebus_ds          <= '0;
      ebus_diag_strobe <= 1'b0;
      drv_on           <= 1'b0;
      mem_req          <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            cmd_op <= fe_op;
            if (is_ebus) begin
              // Cycle 1 puts the function code on the bus
              ebus_ds <= fe_ds;
              drv_on  <= (fe_op == kl10_pkg::OP_EBUS_WR);
              state   <= S_SETUP;
            end else begin
              mem_req <= 1'b1;
              state   <= S_MEM;
            end
          end
        end
        S_SETUP: begin
          ebus_diag_strobe <= (cmd_op == kl10_pkg::OP_EBUS_WR);
          state            <= S_STROBE;
        end
        S_STROBE: begin
          // The addressed board latches on this edge, then the bus goes idle
          ebus_diag_strobe <= 1'b0;
          drv_on           <= 1'b0;
          ebus_ds          <= '0;
          fe_ack           <= 1'b1;
          state            <= S_ACK;
        end
        S_MEM: begin
          if (mem_done) begin
            mem_req <= 1'b0;
            fe_ack  <= 1'b1;
            state   <= S_ACK;
          end
        end
        S_ACK: begin
          if (!fe_req) begin
            fe_ack <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      drv_data  <= fe_wdata;
      mem_wr    <= (fe_op == kl10_pkg::OP_MEM_WR);
      mem_adr   <= fe_adr;
      mem_wdata <= fe_wdata;
    end
    // Read data is held until the next read so it stays valid under fe_ack
    if (state == S_SETUP && cmd_op == kl10_pkg::OP_EBUS_RD) begin
      fe_rdata <= ebus_data;
    end else if (state == S_MEM && mem_done && !mem_wr) begin
      fe_rdata <= mem_rdata;
    end
  end

endmodule

//--- src/mbox_port.sv
`timescale 1ns/1ps

module mbox_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mem_req,
  input  logic               mem_wr,
  input  kl10_pkg::mem_adr_t mem_adr,
  input  kl10_pkg::word_t    mem_wdata,
  output logic               mem_done,
  output kl10_pkg::word_t    mem_rdata,
  mbus_if.mbox               mbus
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_START,
    M_READ
  } state_t;

  state_t state;
  logic   accept;

  // mem_req is still high in the cycle after done, so done blocks a restart
  assign accept = (state == M_IDLE) && mem_req && !mem_done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= M_IDLE;
      mem_done   <= 1'b0;
      mbus.start <= 1'b0;
      mbus.rd_rq <= 1'b0;
      mbus.wr_rq <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (accept) begin
            mbus.start <= 1'b1;
            mbus.rd_rq <= !mem_wr;
            mbus.wr_rq <= mem_wr;
            state      <= M_START;
          end
        end
        M_START: begin
          if (mbus.ackn) begin
            mbus.start <= 1'b0;
            mbus.rd_rq <= 1'b0;
            mbus.wr_rq <= 1'b0;
            // A write is finished at acknowledge, a read waits for data
            if (mbus.wr_rq) begin
              mem_done <= 1'b1;
              state    <= M_IDLE;
            end else begin
              state <= M_READ;
            end
          end
        end
        M_READ: begin
          if (mbus.in_valid) begin
            mem_done <= 1'b1;
            state    <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mbus.adr   <= mem_adr;
      mbus.d_out <= mem_wdata;
    end
    if (state == M_READ && mbus.in_valid) begin
      mem_rdata <= mbus.d_in;
    end
  end

endmodule

//--- src/mb20_mem.sv
`timescale 1ns/1ps

// Single bank memory controller on the MBUS
module mb20_mem #(
  parameter int MEMSIZE = kl10_pkg::MEM_WORDS
) (
  input  logic   clk,
  input  logic   rst_n,
  mbus_if.memory mbus
);

  localparam int AW = (MEMSIZE > 1) ? $clog2(MEMSIZE) : 1;

  typedef enum logic [1:0] {
    R_IDLE,
    R_ACK,
    R_READ
  } state_t;

  state_t          state;
  logic [3:0]      cnt;
  logic [AW-1:0]   idx;
  logic            is_wr;
  logic            accept;
  logic            wr_now;
  kl10_pkg::word_t mem [MEMSIZE];

  // start is still up in the cycle after ackn, so ackn blocks a second cycle
  assign accept = (state == R_IDLE) && mbus.start && (mbus.rd_rq || mbus.wr_rq) && !mbus.ackn;
  assign wr_now = (state == R_ACK) && (cnt == '0) && is_wr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= R_IDLE;
      cnt           <= '0;
      mbus.ackn     <= 1'b0;
      mbus.in_valid <= 1'b0;
    end else begin
      mbus.ackn     <= 1'b0;
      mbus.in_valid <= 1'b0;
      case (state)
        R_IDLE: begin
          if (accept) begin
            cnt   <= 4'(kl10_pkg::MEM_ACK_DELAY - 1);
            state <= R_ACK;
          end
        end
        R_ACK: begin
          if (cnt == '0) begin
            mbus.ackn <= 1'b1;
            if (is_wr) begin
              state <= R_IDLE;
            end else begin
              cnt   <= 4'(kl10_pkg::MEM_READ_DELAY - 1);
              state <= R_READ;
            end
          end else begin
            cnt <= cnt - 4'd1;
          end
        end
        R_READ: begin
          if (cnt == '0) begin
            mbus.in_valid <= 1'b1;
            state         <= R_IDLE;
          end else begin
            cnt <= cnt - 4'd1;
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // Addresses beyond the array wrap around
  always_ff @(posedge clk) begin
    if (accept) begin
      idx   <= AW'(mbus.adr % MEMSIZE);
      is_wr <= mbus.wr_rq;
    end
    if (wr_now) begin
      mem[idx] <= mbus.d_out;
    end
    if (state == R_READ && cnt == '0) begin
      mbus.d_in <= mem[idx];
    end
  end

endmodule

//--- src/kl10_ebus_top.sv
`timescale 1ns/1ps

module kl10_ebus_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fe_req,
  input  kl10_pkg::fe_op_t   fe_op,
  input  kl10_pkg::ds_t      fe_ds,
  input  kl10_pkg::mem_adr_t fe_adr,
  input  kl10_pkg::word_t    fe_wdata,
  output logic               fe_ack,
  output kl10_pkg::word_t    fe_rdata
);

  kl10_pkg::ds_t          ebus_ds;
  logic                   ebus_diag_strobe;
  kl10_pkg::word_t        ebus_data;
  kl10_pkg::ebus_driver_t fe_drv;
  kl10_pkg::ebus_driver_t apr_drv;
  kl10_pkg::ebus_driver_t ctl_drv;
  kl10_pkg::ebus_driver_t edp_drv [kl10_pkg::EDP_SLICES];

  logic                   mem_req;
  logic                   mem_wr;
  kl10_pkg::mem_adr_t     mem_adr;
  kl10_pkg::word_t        mem_wdata;
  logic                   mem_done;
  kl10_pkg::word_t        mem_rdata;

  mbus_if mbus ();

  fe_diag_port u_fe (
    .clk, .rst_n, .fe_req, .fe_op, .fe_ds, .fe_adr, .fe_wdata,
    .ebus_data, .mem_done, .mem_rdata,
    .fe_ack, .fe_rdata, .ebus_ds, .ebus_diag_strobe, .fe_drv,
    .mem_req, .mem_wr, .mem_adr, .mem_wdata
  );

  ebus_mux u_mux (
    .fe_drv, .apr_drv, .ctl_drv, .edp_drv, .ebus_data
  );

  ebus_slot #(.payload_t(kl10_pkg::word_t), .BOARD(kl10_pkg::DS_BRD_APR), .LSB(35)) u_apr (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(apr_drv)
  );

  ebus_slot #(.payload_t(kl10_pkg::word_t), .BOARD(kl10_pkg::DS_BRD_CTL), .LSB(35)) u_ctl (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(ctl_drv)
  );

  // Slice 0 of the EDP carries the low order bits 30..35
  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(35)) u_edp0 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[0])
  );

  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(29)) u_edp1 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[1])
  );

  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(23)) u_edp2 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[2])
  );

  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(17)) u_edp3 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[3])
  );

  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(11)) u_edp4 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[4])
  );

  ebus_slot #(.payload_t(kl10_pkg::slice_t), .BOARD(kl10_pkg::DS_BRD_EDP), .LSB(5)) u_edp5 (
    .clk, .rst_n, .ebus_ds, .ebus_diag_strobe, .ebus_data, .drv(edp_drv[5])
  );

  mbox_port u_mbox (
    .clk, .rst_n, .mem_req, .mem_wr, .mem_adr, .mem_wdata,
    .mem_done, .mem_rdata, .mbus(mbus.mbox)
  );

  mb20_mem #(.MEMSIZE(kl10_pkg::MEM_WORDS)) u_mem (
    .clk, .rst_n, .mbus(mbus.memory)
  );

endmodule

//--- bench/kl10_ebus_assert.sv
`timescale 1ns/1ps

// Handshake and bus protocol properties of the front end port
module kl10_ebus_assert (
  input logic             clk,
  input logic             rst_n,
  input logic             fe_req,
  input logic             fe_ack,
  input kl10_pkg::fe_op_t fe_op,
  input kl10_pkg::word_t  fe_rdata,
  input logic             ebus_diag_strobe,
  input logic             mem_req
);

  int   fail_count = 0;
  logic ebus_op;

  assign ebus_op = (fe_op == kl10_pkg::OP_EBUS_RD) || (fe_op == kl10_pkg::OP_EBUS_WR);

  ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !fe_ack)
    else begin
      fail_count++;
      $error("fe_ack was high in the cycle after reset");
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fe_ack) |-> fe_req)
    else begin
      fail_count++;
      $error("fe_ack rose while fe_req was low");
    end

  ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(fe_req) |-> ##[0:1] !fe_ack)
    else begin
      fail_count++;
      $error("fe_ack stayed high more than one cycle after fe_req fell");
    end

  // An accepted EBUS command is acknowledged on the third cycle
  ebus_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fe_req) && ebus_op |=> !fe_ack ##1 !fe_ack ##1 fe_ack)
    else begin
      fail_count++;
      $error("EBUS command was not acknowledged exactly three cycles after fe_req");
    end

  rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
    fe_ack && $past(fe_ack) |-> $stable(fe_rdata))
    else begin
      fail_count++;
      $error("fe_rdata changed while fe_ack was high");
    end

  strobe_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    ebus_diag_strobe |=> !ebus_diag_strobe && !mem_req)
    else begin
      fail_count++;
      $error("Diagnostic strobe was longer than one cycle or overlapped a memory request");
    end

endmodule

bind kl10_ebus_top kl10_ebus_assert u_assert (
  .clk(clk),
  .rst_n(rst_n),
  .fe_req(fe_req),
  .fe_ack(fe_ack),
  .fe_op(fe_op),
  .fe_rdata(fe_rdata),
  .ebus_diag_strobe(ebus_diag_strobe),
  .mem_req(mem_req)
);

//--- bench/kl10_ebus_tb.sv
`timescale 1ns/1ps

module kl10_ebus_tb;

  localparam logic [31:0] SEED    = 32'h408e_b6c1;
  localparam int          TIMEOUT = 50;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               fe_req;
  kl10_pkg::fe_op_t   fe_op;
  kl10_pkg::ds_t      fe_ds;
  kl10_pkg::mem_adr_t fe_adr;
  kl10_pkg::word_t    fe_wdata;
  logic               fe_ack;
  kl10_pkg::word_t    fe_rdata;

  logic [31:0]        rng;
  int                 errors;
  int                 assert_errors;
  kl10_pkg::word_t    w;
  kl10_pkg::word_t    wr_rdata;
  kl10_pkg::word_t    apr_model;
  kl10_pkg::word_t    ctl_model;
  kl10_pkg::word_t    edp_model;
  kl10_pkg::word_t    mem_model [int];
  kl10_pkg::mem_adr_t adr_q [$];
  kl10_pkg::mem_adr_t a;

  kl10_ebus_top u_kl10_ebus_top (
    .clk, .rst_n, .fe_req, .fe_op, .fe_ds, .fe_adr, .fe_wdata, .fe_ack, .fe_rdata
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_word(output kl10_pkg::word_t nw);
    logic [31:0] hi;
    rng = xorshift(rng);
    hi  = rng;
    rng = xorshift(rng);
    nw  = {hi[3:0], rng};
  endtask

  // Runs one four-phase command and samples outputs on the falling edge
  task automatic run_cmd(input kl10_pkg::fe_op_t op, input kl10_pkg::ds_t ds,
                         input kl10_pkg::mem_adr_t adr, input kl10_pkg::word_t wdata,
                         output kl10_pkg::word_t rdata);
    int n;
    @(posedge clk);
    fe_req   <= 1'b1;
    fe_op    <= op;
    fe_ds    <= ds;
    fe_adr   <= adr;
    fe_wdata <= wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!fe_ack && n < TIMEOUT);
    if (!fe_ack) begin
      $display("Timed out at %0t waiting for fe_ack to rise", $time);
      errors++;
    end
    rdata = fe_rdata;
    @(posedge clk);
    fe_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (fe_ack && n < TIMEOUT);
    if (fe_ack) begin
      $display("Timed out at %0t waiting for fe_ack to fall", $time);
      errors++;
    end
  endtask

  task automatic check_word(input kl10_pkg::word_t got, input kl10_pkg::word_t exp,
                            input string what);
    assert (got === exp)
      else begin
        $display("ERROR %0t: %s returned %h, expected %h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic diag_write(input kl10_pkg::ds_brd_t brd, input kl10_pkg::word_t data);
    kl10_pkg::word_t unused;
    run_cmd(kl10_pkg::OP_EBUS_WR, {brd, kl10_pkg::DS_FN_WRITE}, '0, data, unused);
  endtask

  task automatic diag_read(input kl10_pkg::ds_brd_t brd, input kl10_pkg::word_t exp,
                           input string what);
    kl10_pkg::word_t got;
    run_cmd(kl10_pkg::OP_EBUS_RD, {brd, kl10_pkg::DS_FN_READ}, '0, '0, got);
    check_word(got, exp, what);
  endtask

  initial begin
    rst_n     = 1'b0;
    fe_req    = 1'b0;
    fe_op     = kl10_pkg::OP_EBUS_RD;
    fe_ds     = '0;
    fe_adr    = '0;
    fe_wdata  = '0;
    errors    = 0;
    rng       = SEED;
    apr_model = '0;
    ctl_model = '0;
    edp_model = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Slot registers come out of reset as zero
    diag_read(kl10_pkg::DS_BRD_APR, apr_model, "APR read after reset");
    diag_read(kl10_pkg::DS_BRD_EDP, edp_model, "EDP read after reset");

    for (int i = 0; i < 4; i++) begin
      next_word(apr_model);
      diag_write(kl10_pkg::DS_BRD_APR, apr_model);
      diag_read(kl10_pkg::DS_BRD_CTL, ctl_model, "CTL read after APR write");
      next_word(ctl_model);
      diag_write(kl10_pkg::DS_BRD_CTL, ctl_model);
      diag_read(kl10_pkg::DS_BRD_APR, apr_model, "APR read");
      diag_read(kl10_pkg::DS_BRD_CTL, ctl_model, "CTL read");
      next_word(edp_model);
      diag_write(kl10_pkg::DS_BRD_EDP, edp_model);
      diag_read(kl10_pkg::DS_BRD_EDP, edp_model, "EDP split word read");
    end

    // No slot answers these board codes
    diag_read(4'h0, '0, "Read of board 0");
    diag_read(4'hf, '0, "Read of board 17");

    // The memory wraps its address modulo its size
    for (int i = 0; i < 6; i++) begin
      rng = xorshift(rng);
      a   = rng[21:0];
      next_word(w);
      run_cmd(kl10_pkg::OP_MEM_WR, '0, a, w, wr_rdata);
      mem_model[int'(a) % kl10_pkg::MEM_WORDS] = w;
      adr_q.push_back(a);
    end
    foreach (adr_q[i]) begin
      run_cmd(kl10_pkg::OP_MEM_RD, '0, adr_q[i], '0, w);
      check_word(w, mem_model[int'(adr_q[i]) % kl10_pkg::MEM_WORDS], "Memory read");
    end

    assert_errors = u_kl10_ebus_top.u_assert.fail_count;
    $display("Run complete with %0d testbench errors and %0d assertion errors",
             errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- kl10_ebus.f
src/kl10_pkg.sv
src/mbus_if.sv
src/ebus_slot.sv
src/ebus_mux.sv
src/fe_diag_port.sv
src/mbox_port.sv
src/mb20_mem.sv
src/kl10_ebus_top.sv
bench/kl10_ebus_assert.sv
bench/kl10_ebus_tb.sv

//--- Bender.yml
package:
  name: kl10_ebus

sources:
  - src/kl10_pkg.sv
  - src/mbus_if.sv
  - src/ebus_slot.sv
  - src/ebus_mux.sv
  - src/fe_diag_port.sv
  - src/mbox_port.sv
  - src/mb20_mem.sv
  - src/kl10_ebus_top.sv
  - target: simulation
    files:
      - bench/kl10_ebus_assert.sv
      - bench/kl10_ebus_tb.sv
